/* junction_vectors.txt */
# S c0..c15 sweepstart chunks, A row a0..a7 activations, W row w0..w7 weights
# E group n0 n1 expected neurons, R mode name (0 plain, 1 start held busy, 2 back to back)
# Pattern A, activation equals its address, unit weights
S 0 0 1 1 2 3 3 0 1 2 2 2 0 0 1 3
A 0 0 1 2 3 4 5 6 7
A 1 8 9 10 11 12 13 14 15
A 2 16 17 18 19 20 21 22 23
A 3 24 25 26 27 28 29 30 31
W 0 1 1 1 1 1 1 1 1
W 1 1 1 1 1 1 1 1 1
W 2 1 1 1 1 1 1 1 1
W 3 1 1 1 1 1 1 1 1
W 4 1 1 1 1 1 1 1 1
W 5 1 1 1 1 1 1 1 1
W 6 1 1 1 1 1 1 1 1
W 7 1 1 1 1 1 1 1 1
E 0 22 86
E 1 54 54
E 2 86 54
E 3 54 86
E 4 62 54
E 5 94 54
E 6 30 86
E 7 30 86
R 0 pattern_a
# Pattern B over the same stores
S 3 0 0 1 2 2 1 3 1 2 3 3 0 0 2 1
E 0 38 86
E 1 38 86
E 2 70 54
E 3 70 54
E 4 78 46
E 5 46 78
E 6 46 78
E 7 46 78
R 0 pattern_b
# Row values -100 20 5 90 push sums below 0 and above 127
A 0 -100 -100 -100 -100 -100 -100 -100 -100
A 1 20 20 20 20 20 20 20 20
A 2 5 5 5 5 5 5 5 5
A 3 90 90 90 90 90 90 90 90
E 0 0 120
E 1 0 85
E 2 120 0
E 3 85 0
E 4 127 0
E 5 0 127
E 6 30 0
E 7 0 100
R 0 relu_saturate
R 1 start_while_busy
R 2 back_to_back

/* junction.f */
junction_pkg.sv
interleaver_set.sv
banked_store.sv
neuron_accum.sv
junction_ctrl.sv
junction_top.sv
junction_tb.sv

/* Bender.yml */
package:
  name: junction

sources:
  - junction_pkg.sv
  - interleaver_set.sv
  - banked_store.sv
  - neuron_accum.sv
  - junction_ctrl.sv
  - junction_top.sv
  - target: test
    files:
      - junction_tb.sv

/* junction_tb.sv */
// Testbench for the junction datapath, driven by the vector file, with per-test reports
module junction_tb;

	import junction_pkg::*;

	localparam int P         = P_DEF;
	localparam int N         = N_DEF;
	localparam int FO        = FO_DEF;
	localparam int FI        = FI_DEF;
	localparam int Z         = Z_DEF;
	// One group per cycle index
	localparam int GROUPS    = FO * P / Z;
	localparam int NG        = Z / FI;
	localparam int AA_W      = $clog2(P);
	localparam int WA_W      = $clog2(FO * P);
	localparam int SA_W      = $clog2(FO * Z);
	localparam int SD_W      = $clog2(P / Z);
	localparam int IX_W      = $clog2(N);
	// Falling edges from driving start to the first group
	localparam int LAT       = 3;
	// Quiet edges watched after a pass
	localparam int TAIL      = 6;
	// Reset check plus the five passes in the vector file
	localparam int NUM_TESTS = 6;

	logic                reset;
	logic                rst_n_i;
	logic                start_i;
	logic                act_we_i;
	logic [AA_W-1:0]     act_addr_i;
	act_t                act_data_i;
	logic                wt_we_i;
	logic [WA_W-1:0]     wt_addr_i;
	wt_t                 wt_data_i;
	logic                ss_we_i;
	logic [SA_W-1:0]     ss_addr_i;
	logic [SD_W-1:0]     ss_data_i;
	logic                busy_o;
	logic                done_o;
	logic                out_valid_o;
	logic [IX_W-1:0]     out_index_o;
	act_t [NG-1:0]       out_data_o;

	// Expected neurons per group as given by E records
	int exp_data [GROUPS][NG];
	// Errors since the last report
	int errors;
	int tests_passed;
	int tests_failed;
	int cycles;
	int cycle_limit;

	junction_top #(.P(P), .N(N), .FO(FO), .FI(FI), .Z(Z)) DUT (
		.reset       (reset),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.act_we_i    (act_we_i),
		.act_addr_i  (act_addr_i),
		.act_data_i  (act_data_i),
		.wt_we_i     (wt_we_i),
		.wt_addr_i   (wt_addr_i),
		.wt_data_i   (wt_data_i),
		.ss_we_i     (ss_we_i),
		.ss_addr_i   (ss_addr_i),
		.ss_data_i   (ss_data_i),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.out_valid_o (out_valid_o),
		.out_index_o (out_index_o),
		.out_data_o  (out_data_o)
	);

	// 10 unit clock
	initial reset = 1'b0;
	always #5 reset = ~reset;

	// Watchdog whose limit grows as records are read
	always @(posedge reset) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// One falling edge with no pass active
	task automatic idle_tick();
		@(negedge reset);
		if (busy_o !== 1'b0 || done_o !== 1'b0 || out_valid_o !== 1'b0) begin
			$display("ERROR t=%0t busy_o/done_o/out_valid_o expected 0/0/0 got %b/%b/%b",
				$time, busy_o, done_o, out_valid_o);
			errors++;
		end
	endtask

	task automatic read_value(input int fd, output int v);
		int r;
		r = $fscanf(fd, "%d", v);
		if (r != 1) begin
			$display("Vector file ended in the middle of a record");
			errors++;
			v = 0;
		end
	endtask

	// S record holds all sweepstart chunks in address order
	task automatic load_sweepstart(input int fd);
		int v;
		for (int j = 0; j < FO * Z; j++) begin
			read_value(fd, v);
			idle_tick();
			ss_we_i   = 1'b1;
			ss_addr_i = SA_W'(j);
			ss_data_i = SD_W'(v);
		end
		idle_tick();
		ss_we_i = 1'b0;
	endtask

	// A or W record holds one row of Z words
	task automatic load_row(input int fd, input bit is_wt);
		int row;
		int v;
		read_value(fd, row);
		for (int j = 0; j < Z; j++) begin
			read_value(fd, v);
			idle_tick();
			if (is_wt) begin
				wt_we_i   = 1'b1;
				wt_addr_i = WA_W'(row * Z + j);
				wt_data_i = wt_t'(v);
			end else begin
				act_we_i   = 1'b1;
				act_addr_i = AA_W'(row * Z + j);
				act_data_i = act_t'(v);
			end
		end
		idle_tick();
		act_we_i = 1'b0;
		wt_we_i  = 1'b0;
	endtask

	task automatic report_test(input logic [8*32-1:0] name);
		if (errors == 0) begin
			$display("Test %0s: PASS", name);
			tests_passed++;
		end else begin
			$display("Test %0s: FAIL with %0d errors", name, errors);
			tests_failed++;
		end
		errors = 0;
	endtask

	// Index, arrival edge and data of one output group
	task automatic check_group(input int grp, input int since);
		if (grp >= GROUPS) begin
			$display("Extra output group after the last one at t=%0t", $time);
			errors++;
		end else begin
			if (since != grp + LAT) begin
				$display("Group %0d came %0d cycles after start instead of %0d",
					grp, since, grp + LAT);
				errors++;
			end
			if (out_index_o !== IX_W'(grp * NG)) begin
				$display("ERROR t=%0t out_index_o expected %0d got %0d",
					$time, grp * NG, out_index_o);
				errors++;
			end
			for (int g = 0; g < NG; g++) begin
				if (out_data_o[g] !== act_t'(exp_data[grp][g])) begin
					$display("ERROR t=%0t out_data_o[%0d] expected %0d got %0d",
						$time, g, exp_data[grp][g], out_data_o[g]);
					errors++;
				end
			end
		end
	endtask

	// Mode 0 runs a plain pass, 1 holds start while busy, 2 adds a pass right after done
	task automatic run_test(input int mode, input logic [8*32-1:0] name);
		int passes;
		int hold;
		int grp;
		int since;
		bit seen_done;
		passes = (mode == 2) ? 2 : 1;
		cycle_limit += passes * (GROUPS + 10);
		@(negedge reset);
		for (int pass = 0; pass < passes; pass++) begin
			// A later pass starts on the edge where done_o was seen
			start_i   = 1'b1;
			hold      = (mode == 1 && pass == 0) ? 4 : 1;
			grp       = 0;
			since     = 0;
			seen_done = 1'b0;
			while (!seen_done) begin
				@(negedge reset);
				since++;
				if (since == hold) begin
					start_i = 1'b0;
				end
				if (done_o !== 1'b1 && busy_o !== 1'b1) begin
					$display("ERROR t=%0t busy_o expected 1 got %b", $time, busy_o);
					errors++;
				end
				if (out_valid_o === 1'b1) begin
					check_group(grp, since);
					grp++;
				end
				if (done_o === 1'b1) begin
					seen_done = 1'b1;
					if (out_valid_o !== 1'b1) begin
						$display("done_o pulsed without the last group at t=%0t", $time);
						errors++;
					end
					// Busy drops together with done
					if (busy_o !== 1'b0) begin
						$display("ERROR t=%0t busy_o expected 0 got %b", $time, busy_o);
						errors++;
					end
					if (grp != GROUPS) begin
						$display("Pass ended after %0d groups instead of %0d", grp, GROUPS);
						errors++;
					end
				end
			end
		end
		// No further groups or done pulses
		for (int k = 0; k < TAIL; k++) begin
			idle_tick();
		end
		report_test(name);
	endtask

	initial begin
		int fd;
		int r;
		int mode;
		int grp;
		logic [8*8-1:0]   tag;
		logic [8*32-1:0]  name;
		logic [8*256-1:0] line;
		rst_n_i      = 1'b0;
		start_i      = 1'b0;
		act_we_i     = 1'b0;
		act_addr_i   = '0;
		act_data_i   = '0;
		wt_we_i      = 1'b0;
		wt_addr_i    = '0;
		wt_data_i    = '0;
		ss_we_i      = 1'b0;
		ss_addr_i    = '0;
		ss_data_i    = '0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles       = 0;
		cycle_limit  = 20;
		repeat (3) @(negedge reset);
		rst_n_i = 1'b1;
		// Outputs quiet after reset
		for (int k = 0; k < 4; k++) begin
			idle_tick();
		end
		report_test("reset_idle");
		fd = $fopen("junction_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open junction_vectors.txt");
			tests_failed++;
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					r = $fgets(line, fd);
				end else if (tag == "S") begin
					cycle_limit += FO * Z + 1;
					load_sweepstart(fd);
				end else if (tag == "A" || tag == "W") begin
					cycle_limit += Z + 1;
					load_row(fd, tag == "W");
				end else if (tag == "E") begin
					read_value(fd, grp);
					for (int g = 0; g < NG; g++) begin
						read_value(fd, exp_data[grp % GROUPS][g]);
					end
				end else if (tag == "R") begin
					read_value(fd, mode);
					r = $fscanf(fd, "%s", name);
					run_test(mode, name);
				end else begin
					$display("Unknown record %0s in the vector file", tag);
					tests_failed++;
				end
			end
			$fclose(fd);
		end
		if (tests_passed + tests_failed != NUM_TESTS) begin
			$display("Ran %0d tests, the vector file should give %0d",
				tests_passed + tests_failed, NUM_TESTS);
		end
		if (errors != 0) begin
			$display("Vector file left %0d errors outside any test", errors);
		end
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && tests_passed == NUM_TESTS && errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* junction_top.sv */
// Junction top level joining controller, interleaver, activation and weight stores, accumulator
module junction_top #(
	parameter int P  = junction_pkg::P_DEF,
	parameter int N  = junction_pkg::N_DEF,
	parameter int FO = junction_pkg::FO_DEF,
	parameter int FI = junction_pkg::FI_DEF,
	parameter int Z  = junction_pkg::Z_DEF
) (
	input  logic                             reset,
	input  logic                             rst_n_i,
	input  logic                             start_i,
	// Activation load, left neuron index
	input  logic                             act_we_i,
	input  logic [$clog2(P)-1:0]             act_addr_i,
	input  junction_pkg::act_t               act_data_i,
	// Weight load, weight index
	input  logic                             wt_we_i,
	input  logic [$clog2(FO*P)-1:0]          wt_addr_i,
	input  junction_pkg::wt_t                wt_data_i,
	// Sweepstart load, chunk index
	input  logic                             ss_we_i,
	input  logic [$clog2(FO*Z)-1:0]          ss_addr_i,
	input  logic [$clog2(P/Z)-1:0]           ss_data_i,
	// Pass status and results
	output logic                             busy_o,
	output logic                             done_o,
	output logic                             out_valid_o,
	output logic [$clog2(N)-1:0]             out_index_o,
	output junction_pkg::act_t [Z/FI-1:0]    out_data_o
);

	import junction_pkg::*;

	localparam int CI_W = $clog2(FO * P / Z);
	localparam int CH_W = $clog2(P / Z);
	localparam int ZB   = $clog2(Z);

	logic [CI_W-1:0]        cycle_index;
	logic                   rd_en;
	// Activation row per bank from the interleaver
	logic [Z-1:0][CH_W-1:0] act_row;
	act_t [Z-1:0]           act_rd;
	wt_t  [Z-1:0]           wt_rd;

	junction_ctrl #(.P(P), .N(N), .FO(FO), .FI(FI), .Z(Z)) u_ctrl (
		.reset         (reset),
		.rst_n_i       (rst_n_i),
		.start_i       (start_i),
		.cycle_index_o (cycle_index),
		.rd_en_o       (rd_en),
		.busy_o        (busy_o),
		.done_o        (done_o),
		.out_valid_o   (out_valid_o),
		.out_index_o   (out_index_o)
	);

	interleaver_set #(.P(P), .FO(FO), .Z(Z)) u_interleaver (
		.reset         (reset),
		.rst_n_i       (rst_n_i),
		.ss_we_i       (ss_we_i),
		.ss_addr_i     (ss_addr_i),
		.ss_data_i     (ss_data_i),
		.cycle_index_i (cycle_index),
		.bank_row_o    (act_row)
	);

	// Neuron index mod Z picks the bank, index div Z the row
	banked_store #(.Z(Z), .DEPTH(P / Z), .elem_t(act_t)) u_act_store (
		.reset     (reset),
		.we_i      (act_we_i),
		.wr_bank_i (act_addr_i[ZB-1:0]),
		.wr_row_i  (act_addr_i[$clog2(P)-1:ZB]),
		.wr_data_i (act_data_i),
		.rd_en_i   (rd_en),
		.rd_row_i  (act_row),
		.rd_data_o (act_rd)
	);

	// Weights are stored in cycle order
	// Every bank reads the row equal to the cycle index
	banked_store #(.Z(Z), .DEPTH(FO * P / Z), .elem_t(wt_t)) u_wt_store (
		.reset     (reset),
		.we_i      (wt_we_i),
		.wr_bank_i (wt_addr_i[ZB-1:0]),
		.wr_row_i  (wt_addr_i[$clog2(FO*P)-1:ZB]),
		.wr_data_i (wt_data_i),
		.rd_en_i   (rd_en),
		.rd_row_i  ({Z{cycle_index}}),
		.rd_data_o (wt_rd)
	);

	neuron_accum #(.Z(Z), .FI(FI)) u_accum (
		.reset    (reset),
		.rst_n_i  (rst_n_i),
		.act_i    (act_rd),
		.wt_i     (wt_rd),
		.neuron_o (out_data_o)
	);

endmodule

/* junction_ctrl.sv */
// Junction controller with start handling, cycle counter, valid pipeline, busy and done
module junction_ctrl #(
	parameter int P  = junction_pkg::P_DEF,
	parameter int N  = junction_pkg::N_DEF,
	parameter int FO = junction_pkg::FO_DEF,
	parameter int FI = junction_pkg::FI_DEF,
	parameter int Z  = junction_pkg::Z_DEF
) (
	input  logic                          reset,
	input  logic                          rst_n_i,
	input  logic                          start_i,
	output logic [$clog2(FO*P/Z)-1:0]     cycle_index_o,
	output logic                          rd_en_o,
	output logic                          busy_o,
	output logic                          done_o,
	output logic                          out_valid_o,
	output logic [$clog2(N)-1:0]          out_index_o
);

	localparam int CI_W  = $clog2(FO * P / Z);
	localparam int IDX_W = $clog2(N);
	// Right neurons finished per cycle
	localparam int NPC   = Z / FI;
	localparam logic [CI_W-1:0] LAST_CI = CI_W'(FO * P / Z - 1);

	// Pass in progress, held until the last group leaves
	logic            busy_q;
	// Cycle indices still being issued
	logic            run_q;
	logic [CI_W-1:0] cnt_q;
	// Store read stage and accumulator stage
	logic            v1_q;
	logic            v2_q;
	logic            last1_q;
	logic            last2_q;
	logic [CI_W-1:0] grp1_q;
	logic [CI_W-1:0] grp2_q;

	logic launch;
	logic issue_last;

	// Start only counts while idle
	assign launch     = start_i & ~busy_q;
	assign issue_last = run_q & (cnt_q == LAST_CI);

	always_ff @(posedge reset) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			run_q   <= 1'b0;
			cnt_q   <= '0;
			v1_q    <= 1'b0;
			v2_q    <= 1'b0;
			last1_q <= 1'b0;
			last2_q <= 1'b0;
		end else begin
			// Busy drops as the last group reaches the output
			if (launch) begin
				busy_q <= 1'b1;
			end else if (last1_q) begin
				busy_q <= 1'b0;
			end
			// Counter rests at zero between passes
			if (launch) begin
				run_q <= 1'b1;
			end else if (issue_last) begin
				run_q <= 1'b0;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// Two stages match store and accumulator latency
			v1_q    <= run_q;
			v2_q    <= v1_q;
			last1_q <= issue_last;
			last2_q <= last1_q;
		end
	end

	// Group number follows its valid bit
	always_ff @(posedge reset) begin
		grp1_q <= cnt_q;
		grp2_q <= grp1_q;
	end

	assign cycle_index_o = cnt_q;
	assign rd_en_o       = run_q;
	assign busy_o        = busy_q;
	assign done_o        = last2_q;
	assign out_valid_o   = v2_q;
	// First neuron of the group
	assign out_index_o   = IDX_W'(grp2_q * NPC);

endmodule

/* neuron_accum.sv */
// Neuron accumulator with Z multipliers, fan-in adder groups, ReLU, saturation and output register
module neuron_accum #(
	parameter int Z  = junction_pkg::Z_DEF,
	parameter int FI = junction_pkg::FI_DEF
) (
	input  logic                             reset,
	input  logic                             rst_n_i,
	// Activations and weights of one cycle, lane j pairs with lane j
	input  junction_pkg::act_t [Z-1:0]       act_i,
	input  junction_pkg::wt_t  [Z-1:0]       wt_i,
	// Z/FI finished right neurons
	output junction_pkg::act_t [Z/FI-1:0]    neuron_o
);

	import junction_pkg::*;

	// Neurons completed per cycle
	localparam int NG = Z / FI;

	// Per-lane products
	acc_t prod [Z];
	// Per-neuron sums
	acc_t sum [NG];
	// Clamped neuron values
	act_t [NG-1:0] relu;

	// Signed multiply in accumulator width
	// Both operands sign extended before the product
	always_comb begin
		for (int j = 0; j < Z; j++) begin
			prod[j] = acc_t'(act_i[j]) * acc_t'(wt_i[j]);
		end
	end

	// Lanes g*FI to g*FI+FI-1 belong to neuron g of this cycle
	always_comb begin
		for (int g = 0; g < NG; g++) begin
			sum[g] = '0;
			for (int f = 0; f < FI; f++) begin
				sum[g] = sum[g] + prod[g*FI+f];
			end
		end
	end

	// ReLU clears negative sums
	// Positive sums clamp at ACT_MAX
	always_comb begin
		for (int g = 0; g < NG; g++) begin
			if (sum[g] < 0) begin
				relu[g] = '0;
			end else if (sum[g] > acc_t'(ACT_MAX)) begin
				relu[g] = act_t'(ACT_MAX);
			end else begin
				relu[g] = act_t'(sum[g]);
			end
		end
	end

	// One cycle of latency
	always_ff @(posedge reset) begin
		if (!rst_n_i) begin
			neuron_o <= '0;
		end else begin
			neuron_o <= relu;
		end
	end

endmodule

/* banked_store.sv */
// Banked store with Z single-port banks, strobe writes and registered per-bank reads
module banked_store #(
	parameter int  Z      = junction_pkg::Z_DEF,
	parameter int  DEPTH  = junction_pkg::P_DEF / junction_pkg::Z_DEF,
	parameter type elem_t = junction_pkg::act_t
) (
	input  logic                               reset,
	// Write port, one word per strobe
	input  logic                               we_i,
	input  logic [$clog2(Z)-1:0]               wr_bank_i,
	input  logic [$clog2(DEPTH)-1:0]           wr_row_i,
	input  elem_t                              wr_data_i,
	// Read port, one row per bank
	input  logic                               rd_en_i,
	input  logic [Z-1:0][$clog2(DEPTH)-1:0]    rd_row_i,
	output elem_t [Z-1:0]                      rd_data_o
);

	// Z banks of DEPTH words each
	elem_t mem [Z][DEPTH];

	// Loading writes one word into the addressed bank
	always_ff @(posedge reset) begin
		if (we_i) begin
			mem[wr_bank_i][wr_row_i] <= wr_data_i;
		end
	end

	// Every bank reads its own row in parallel
	// Data held while read enable is low
	always_ff @(posedge reset) begin
		if (rd_en_i) begin
			for (int b = 0; b < Z; b++) begin
				rd_data_o[b] <= mem[b][rd_row_i[b]];
			end
		end
	end

endmodule

/* interleaver_set.sv */
// Interleaver with sweepstart register file and cycle index to per-bank row mapping
module interleaver_set #(
	parameter int P  = junction_pkg::P_DEF,
	parameter int FO = junction_pkg::FO_DEF,
	parameter int Z  = junction_pkg::Z_DEF
) (
	input  logic                                 reset,
	input  logic                                 rst_n_i,
	// Sweepstart write strobe
	input  logic                                 ss_we_i,
	input  logic [$clog2(FO*Z)-1:0]              ss_addr_i,
	input  logic [$clog2(P/Z)-1:0]               ss_data_i,
	// Current cycle of the pass
	input  logic [$clog2(FO*P/Z)-1:0]            cycle_index_i,
	// Row each activation bank must read
	output logic [Z-1:0][$clog2(P/Z)-1:0]        bank_row_o
);

	// Chunk width for values 0 to P/Z-1
	localparam int CH_W = $clog2(P / Z);
	// Chunk address width
	localparam int CB_W = $clog2(FO * Z);
	// Bank select width
	localparam int ZB   = $clog2(Z);
	// Number of sweepstart chunks
	localparam int NCH  = FO * Z;

	// Sweepstart chunks with Z per sweep
	// Chunk s*Z+c is the start row of column c in sweep s
	logic [NCH-1:0][CH_W-1:0] ss_q;

	// First chunk of the current sweep
	logic [CB_W-1:0] chunk_base;
	// Row offset inside the sweep
	logic [CH_W-1:0] row_off;
	// Start rows of the current sweep
	logic [Z-1:0][CH_W-1:0] sweep_start;

	// Sweepstart register file
	// Zero after reset and written one chunk per strobe
	always_ff @(posedge reset) begin
		if (!rst_n_i) begin
			ss_q <= '0;
		end else if (ss_we_i) begin
			ss_q[ss_addr_i] <= ss_data_i;
		end
	end

	// Cycle index splits into sweep number and row offset
	// High bits pick the sweep, low CH_W bits give the row within it
	assign row_off = cycle_index_i[CH_W-1:0];

	// Sweep number times Z selects the chunk group
	// Shift result stays below FO*Z
	assign chunk_base = CB_W'(cycle_index_i >> CH_W) << ZB;

	// Gather the Z chunks of the active sweep
	always_comb begin
		for (int c = 0; c < Z; c++) begin
			sweep_start[c] = ss_q[chunk_base + CB_W'(c)];
		end
	end

	// Row for weight i in column c is (start + r) mod P/Z
	// CH_W-bit add wraps at P/Z since P/Z is a power of two
	// Activation address t*Z+c always sits in bank c
	always_comb begin
		for (int c = 0; c < Z; c++) begin
			bank_row_o[c] = sweep_start[c] + row_off;
		end
	end

endmodule

/* junction_pkg.sv */
// Junction package with default geometry, word widths, data types and output limit
package junction_pkg;

	// Default junction geometry
	// Left layer of P neurons feeds right layer of N neurons
	// FO weights leave each left neuron, FI weights enter each right neuron
	// Z weights are handled per clock cycle
	// P/Z, Z and FI are powers of two, and P/Z is at least 2
	localparam int P_DEF  = 32;
	localparam int N_DEF  = 16;
	localparam int FO_DEF = 2;
	localparam int FI_DEF = 4;
	localparam int Z_DEF  = 8;

	// Word widths
	localparam int ACT_W = 8;
	localparam int WT_W  = 8;

	// Accumulator must hold FI full-scale products
	// ACT_W + WT_W bits per product plus clog2(FI) growth bits
	// Extra headroom left for larger fan-in
	localparam int ACC_W = 20;

	// Signed activation word
	typedef logic signed [ACT_W-1:0] act_t;

	// Signed weight word
	typedef logic signed [WT_W-1:0] wt_t;

	// Signed accumulator word
	typedef logic signed [ACC_W-1:0] acc_t;

	// Upper clamp for right layer neurons
	// Largest positive act_t value
	localparam int ACT_MAX = 127;

endpackage
